//--- sd_spi_pkg.sv
/* sd card spi definitions */
`default_nettype none

package sd_spi_pkg;

    // spi or buffer byte
    typedef logic [7:0]  sd_byte_t;
    // sector number towards the io controller
    typedef logic [31:0] sd_lba_t;
    typedef logic [31:0] sd_arg_t;
    // byte index inside one sector
    typedef logic [8:0]  sect_addr_t;

    // fill bytes before R1
    localparam int NCR_BYTES    = 4;
    localparam int SECTOR_BYTES = 512;

    localparam sd_byte_t DATA_TOKEN   = 8'hFE;
    localparam sd_byte_t DATA_RESP_OK = 8'h05;

    // R1 replies
    localparam sd_byte_t R1_READY     = 8'h00;
    localparam sd_byte_t R1_IDLE      = 8'h01;
    localparam sd_byte_t R1_ILLEGAL   = 8'h04;
    localparam sd_byte_t R1_PARAM_ERR = 8'h40;

    // first command byte, 0x40 plus index
    localparam sd_byte_t CMD_GO_IDLE      = 8'h40;
    localparam sd_byte_t CMD_SEND_OP_COND = 8'h41;
    localparam sd_byte_t CMD_SEND_IF_COND = 8'h48;
    localparam sd_byte_t CMD_SEND_STATUS  = 8'h4D;
    localparam sd_byte_t CMD_SET_BLOCKLEN = 8'h50;
    localparam sd_byte_t CMD_READ_SINGLE  = 8'h51;
    localparam sd_byte_t CMD_WRITE_BLOCK  = 8'h58;
    localparam sd_byte_t CMD_APP_OP_COND  = 8'h69;
    localparam sd_byte_t CMD_APP_CMD      = 8'h77;
    localparam sd_byte_t CMD_READ_OCR     = 8'h7A;
    localparam sd_byte_t CMD_CRC_ON_OFF   = 8'h7B;

    // power-up done, standard capacity, 2.7 to 3.6 V window
    localparam sd_arg_t OCR_VALUE = {1'b1, 1'b0, 6'd0, 9'h1FF, 15'd0};

    typedef enum logic [2:0] {
        RD_IDLE, RD_WAIT_IO, RD_TOKEN, RD_DATA, RD_CRC
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE, WR_EXP_TOKEN, WR_DATA, WR_CRC0, WR_CRC1, WR_RESP, WR_BUSY
    } wr_state_e;

endpackage

`default_nettype wire

//--- spi_byte_link.sv
/* spi byte link */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link (
    input  logic                 clk_sys,
    input  logic                 card_is_reset,
    input  logic                 sd_cs,
    input  logic                 sd_sck,
    input  logic                 sd_sdi,
    input  sd_spi_pkg::sd_byte_t tx_byte,
    output logic                 sd_sdo,
    output logic                 rx_valid,
    output sd_spi_pkg::sd_byte_t rx_byte,
    output logic                 byte_start
);
    import sd_spi_pkg::*;

    logic       sck_q;
    logic       sck_rise;
    logic       sck_fall;
    // rising edges seen mod 8
    logic [2:0] bit_cnt;
    logic [6:0] rx_sh;
    sd_byte_t   tx_sh;

    assign sck_rise = ~sck_q & sd_sck;
    assign sck_fall = sck_q & ~sd_sck;

    // first falling edge after the last sample of the previous byte
    assign byte_start = ~sd_cs & sck_fall & (bit_cnt == 3'd0);

    always_ff @(posedge clk_sys) begin
        sck_q    <= sd_sck;
        rx_valid <= 1'b0;
        if (card_is_reset || sd_cs) begin
            bit_cnt <= 3'd0;
            tx_sh   <= 8'hFF;
            // idle line while deselected
            sd_sdo  <= 1'b1;
        end else begin
            // sample on rising sck
            if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                rx_sh   <= {rx_sh[5:0], sd_sdi};
                if (bit_cnt == 3'd7) begin
                    rx_valid <= 1'b1;
                    rx_byte  <= {rx_sh, sd_sdi};
                end
            end
            // drive on falling sck msb first
            if (byte_start) begin
                sd_sdo <= tx_byte[7];
                tx_sh  <= {tx_byte[6:0], 1'b1};
            end else if (sck_fall) begin
                sd_sdo <= tx_sh[7];
                tx_sh  <= {tx_sh[6:0], 1'b1};
            end
        end
    end

    // sck steady for two cycles keeps a sample apart from the next byte start
    assert property (@(posedge clk_sys) disable iff (card_is_reset)
        !(rx_valid && byte_start));

endmodule

`default_nettype wire

//--- sd_cmd_engine.sv
/* sd command decoder */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_engine (
    input  logic                 clk_sys,
    input  logic                 card_is_reset,
    input  logic                 sd_cs,
    input  logic                 rx_valid,
    input  sd_spi_pkg::sd_byte_t rx_byte,
    input  logic                 byte_start,
    input  logic                 xfer_active,
    output sd_spi_pkg::sd_byte_t resp_byte,
    output logic                 start_read,
    output logic                 start_write,
    output sd_spi_pkg::sd_lba_t  lba
);
    import sd_spi_pkg::*;

    // bytes since the command byte, parks at 15
    logic [3:0] byte_cnt;
    sd_byte_t   cmd;
    sd_arg_t    arg;
    logic       go_idle_seen;
    // set by CMD55 for the next command only
    logic       app_cmd;
    logic       pend_rd;
    logic       pend_wr;
    // R1 then up to four extra bytes
    sd_byte_t   reply_q [5];
    logic [3:0] reply_len;
    logic [3:0] slot;
    logic       r1_slot;

    // slot 0 is the fifth byte after the crc byte
    // before that the subtraction wraps far above reply_len
    assign slot      = byte_cnt - 4'(5 + NCR_BYTES);
    assign resp_byte = (slot < reply_len) ? reply_q[slot[2:0]] : 8'hFF;

    // transfers start on the load of R1
    assign r1_slot     = byte_start && (slot == 4'd0) && (reply_len != 4'd0);
    assign start_read  = r1_slot && pend_rd;
    assign start_write = r1_slot && pend_wr;

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            byte_cnt     <= 4'hF;
            reply_len    <= 4'd0;
            go_idle_seen <= 1'b0;
            app_cmd      <= 1'b0;
            pend_rd      <= 1'b0;
            pend_wr      <= 1'b0;
        end else if (sd_cs) begin
            // deselect drops the frame
            byte_cnt  <= 4'hF;
            reply_len <= 4'd0;
            pend_rd   <= 1'b0;
            pend_wr   <= 1'b0;
        end else if (rx_valid) begin
            if (byte_cnt != 4'hF)
                byte_cnt <= byte_cnt + 4'd1;
            // four argument bytes, msb first
            if (byte_cnt < 4'd4)
                arg <= {arg[23:0], rx_byte};
            // new command only after a full frame and no transfer running
            if (byte_cnt >= 4'd5 && !xfer_active && rx_byte[7:6] == 2'b01) begin
                byte_cnt  <= 4'd0;
                cmd       <= rx_byte;
                reply_len <= 4'd0;
                pend_rd   <= 1'b0;
                pend_wr   <= 1'b0;
            end
            // crc byte in, evaluate
            if (byte_cnt == 4'd4) begin
                reply_q[0] <= R1_ILLEGAL;
                reply_len  <= 4'd1;
                app_cmd    <= 1'b0;
                // standard capacity, byte address to sector
                lba        <= {9'd0, arg[31:9]};
                if (cmd == CMD_GO_IDLE) begin
                    go_idle_seen <= 1'b1;
                    reply_q[0]   <= R1_IDLE;
                end else if (go_idle_seen) begin
                    case (cmd)
                        CMD_SEND_OP_COND, CMD_CRC_ON_OFF: reply_q[0] <= R1_READY;
                        CMD_READ_SINGLE: begin
                            reply_q[0] <= R1_READY;
                            pend_rd    <= 1'b1;
                        end
                        CMD_WRITE_BLOCK: begin
                            reply_q[0] <= R1_READY;
                            pend_wr    <= 1'b1;
                        end
                        // echo voltage and check pattern
                        CMD_SEND_IF_COND: begin
                            reply_q[0] <= R1_IDLE;
                            reply_q[1] <= 8'h00;
                            reply_q[2] <= 8'h00;
                            reply_q[3] <= {4'h0, arg[19:16]};
                            reply_q[4] <= arg[7:0];
                            reply_len  <= 4'd5;
                        end
                        CMD_SEND_STATUS: begin
                            reply_q[0] <= R1_READY;
                            reply_q[1] <= 8'h00;
                            reply_len  <= 4'd2;
                        end
                        // only 512 byte blocks
                        CMD_SET_BLOCKLEN:
                            reply_q[0] <= (arg == sd_arg_t'(SECTOR_BYTES)) ?
                                          R1_READY : R1_PARAM_ERR;
                        CMD_APP_CMD: begin
                            reply_q[0] <= R1_IDLE;
                            app_cmd    <= 1'b1;
                        end
                        CMD_APP_OP_COND:
                            reply_q[0] <= app_cmd ? R1_READY : R1_ILLEGAL;
                        CMD_READ_OCR: begin
                            reply_q[0] <= R1_READY;
                            reply_q[1] <= OCR_VALUE[31:24];
                            reply_q[2] <= OCR_VALUE[23:16];
                            reply_q[3] <= OCR_VALUE[15:8];
                            reply_q[4] <= OCR_VALUE[7:0];
                            reply_len  <= 4'd5;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // one transfer at a time, never on top of a running one
    assert property (@(posedge clk_sys) disable iff (card_is_reset)
        (start_read || start_write) |-> !(start_read && start_write) && !xfer_active);

endmodule

`default_nettype wire

//--- sd_block_xfer.sv
/* sd block read and write */
`timescale 1ns/1ps
`default_nettype none

module sd_block_xfer (
    input  logic                   clk_sys,
    input  logic                   card_is_reset,
    input  logic                   sd_cs,
    input  logic                   rx_valid,
    input  sd_spi_pkg::sd_byte_t   rx_byte,
    input  logic                   byte_start,
    input  sd_spi_pkg::sd_byte_t   resp_byte,
    input  logic                   start_read,
    input  logic                   start_write,
    input  sd_spi_pkg::sd_lba_t    lba,
    input  logic                   sd_ack,
    input  sd_spi_pkg::sd_byte_t   buf_rdata,
    output sd_spi_pkg::sd_byte_t   tx_byte,
    output logic                   xfer_active,
    output sd_spi_pkg::sd_lba_t    sd_lba,
    output logic                   sd_rd,
    output logic                   sd_wr,
    output logic                   sd_busy,
    output sd_spi_pkg::sect_addr_t buf_addr,
    output sd_spi_pkg::sd_byte_t   buf_wdata,
    output logic                   buf_we
);
    import sd_spi_pkg::*;

    rd_state_e  rd_state;
    wr_state_e  wr_state;
    logic       ack_q;
    // sector byte pointer that also counts the crc bytes on a read
    sect_addr_t ptr;

    assign xfer_active = (rd_state != RD_IDLE) || (wr_state != WR_IDLE);

    // buffer port b follows the pointer so read data is ready long before byte_start
    assign buf_addr  = ptr;
    assign buf_wdata = rx_byte;
    assign buf_we    = rx_valid && (wr_state == WR_DATA);

    // transfer owns the line or else the command reply passes
    always_comb begin
        tx_byte = resp_byte;
        case (rd_state)
            RD_WAIT_IO, RD_CRC: tx_byte = 8'hFF;
            RD_TOKEN:           tx_byte = DATA_TOKEN;
            RD_DATA:            tx_byte = buf_rdata;
            default:            ;
        endcase
        case (wr_state)
            WR_IDLE: ;
            WR_RESP: tx_byte = DATA_RESP_OK;
            // card busy holds the line low
            WR_BUSY: tx_byte = 8'h00;
            default: tx_byte = 8'hFF;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
            ack_q    <= 1'b0;
            sd_rd    <= 1'b0;
            sd_wr    <= 1'b0;
            sd_busy  <= 1'b0;
        end else begin
            ack_q <= sd_ack;
            // ack rise takes the request and ack fall ends busy
            if (sd_ack && !ack_q) begin
                sd_rd <= 1'b0;
                sd_wr <= 1'b0;
            end
            if (!sd_ack && ack_q)
                sd_busy <= 1'b0;
            if (buf_we)
                ptr <= ptr + 9'd1;

            case (rd_state)
                RD_IDLE:
                    if (start_read) begin
                        sd_lba   <= lba;
                        sd_rd    <= 1'b1;
                        sd_busy  <= 1'b1;
                        ptr      <= '0;
                        rd_state <= RD_WAIT_IO;
                    end
                RD_WAIT_IO:
                    if (!sd_busy)
                        rd_state <= RD_TOKEN;
                RD_TOKEN:
                    if (byte_start)
                        rd_state <= RD_DATA;
                RD_DATA:
                    if (byte_start) begin
                        ptr <= ptr + 9'd1;
                        if (ptr == sect_addr_t'(SECTOR_BYTES - 1))
                            rd_state <= RD_CRC;
                    end
                // two filler crc bytes with ptr wrapped to 0
                RD_CRC:
                    if (byte_start) begin
                        ptr <= ptr + 9'd1;
                        if (ptr[0])
                            rd_state <= RD_IDLE;
                    end
                default: rd_state <= RD_IDLE;
            endcase

            case (wr_state)
                WR_IDLE:
                    if (start_write) begin
                        sd_lba   <= lba;
                        wr_state <= WR_EXP_TOKEN;
                    end
                WR_EXP_TOKEN:
                    if (rx_valid && rx_byte == DATA_TOKEN) begin
                        ptr      <= '0;
                        wr_state <= WR_DATA;
                    end
                WR_DATA:
                    if (buf_we && ptr == sect_addr_t'(SECTOR_BYTES - 1))
                        wr_state <= WR_CRC0;
                WR_CRC0:
                    if (rx_valid)
                        wr_state <= WR_CRC1;
                // sector complete so hand it to the io controller
                WR_CRC1:
                    if (rx_valid) begin
                        sd_wr    <= 1'b1;
                        sd_busy  <= 1'b1;
                        wr_state <= WR_RESP;
                    end
                WR_RESP:
                    if (byte_start)
                        wr_state <= WR_BUSY;
                WR_BUSY:
                    if (!sd_busy)
                        wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase

            // deselect drops a transfer with no io request in flight
            if (sd_cs) begin
                if (rd_state != RD_WAIT_IO)
                    rd_state <= RD_IDLE;
                if (wr_state != WR_RESP && wr_state != WR_BUSY)
                    wr_state <= WR_IDLE;
            end
        end
    end

    assert property (@(posedge clk_sys) disable iff (card_is_reset) !(sd_rd && sd_wr));

    // card writes the buffer only while the io controller is not using it
    assert property (@(posedge clk_sys) disable iff (card_is_reset)
        buf_we |-> !sd_busy);

endmodule

`default_nettype wire

//--- sector_ram.sv
/* sector buffer */
`timescale 1ns/1ps
`default_nettype none

module sector_ram (
    input  logic                   clk_sys,
    input  sd_spi_pkg::sect_addr_t a_addr,
    input  sd_spi_pkg::sd_byte_t   a_wdata,
    input  logic                   a_we,
    output sd_spi_pkg::sd_byte_t   a_rdata,
    input  sd_spi_pkg::sect_addr_t b_addr,
    input  sd_spi_pkg::sd_byte_t   b_wdata,
    input  logic                   b_we,
    output sd_spi_pkg::sd_byte_t   b_rdata
);
    import sd_spi_pkg::*;

    sd_byte_t mem [SECTOR_BYTES];

    // both ports write, read data shows the written byte
    always_ff @(posedge clk_sys) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        if (b_we)
            mem[b_addr] <= b_wdata;
        a_rdata <= a_we ? a_wdata : mem[a_addr];
        b_rdata <= b_we ? b_wdata : mem[b_addr];
    end

endmodule

`default_nettype wire

//--- sd_card_spi.sv
/* spi mode sd card, top level */
`timescale 1ns/1ps
`default_nettype none

module sd_card_spi (
    input  logic                   clk_sys,
    input  logic                   card_is_reset,
    input  logic                   sd_cs,
    input  logic                   sd_sck,
    input  logic                   sd_sdi,
    input  logic                   sd_ack,
    input  sd_spi_pkg::sect_addr_t sd_buff_addr,
    input  sd_spi_pkg::sd_byte_t   sd_buff_dout,
    input  logic                   sd_buff_wr,
    output logic                   sd_sdo,
    output sd_spi_pkg::sd_lba_t    sd_lba,
    output logic                   sd_rd,
    output logic                   sd_wr,
    output logic                   sd_busy,
    output sd_spi_pkg::sd_byte_t   sd_buff_din
);
    import sd_spi_pkg::*;

    sd_byte_t   rx_byte;
    sd_byte_t   tx_byte;
    sd_byte_t   resp_byte;
    sd_byte_t   buf_rdata;
    sd_byte_t   buf_wdata;
    sect_addr_t buf_addr;
    sd_lba_t    lba;
    logic       rx_valid;
    logic       byte_start;
    logic       xfer_active;
    logic       start_read;
    logic       start_write;
    logic       buf_we;
    logic       buff_we_a;

    // io controller writes count only while it holds ack
    assign buff_we_a = sd_buff_wr & sd_ack;

    spi_byte_link link_i (
        .clk_sys(clk_sys), .card_is_reset(card_is_reset), .sd_cs(sd_cs),
        .sd_sck(sd_sck), .sd_sdi(sd_sdi), .tx_byte(tx_byte), .sd_sdo(sd_sdo),
        .rx_valid(rx_valid), .rx_byte(rx_byte), .byte_start(byte_start)
    );

    sd_cmd_engine cmd_i (
        .clk_sys(clk_sys), .card_is_reset(card_is_reset), .sd_cs(sd_cs),
        .rx_valid(rx_valid), .rx_byte(rx_byte), .byte_start(byte_start),
        .xfer_active(xfer_active), .resp_byte(resp_byte), .start_read(start_read),
        .start_write(start_write), .lba(lba)
    );

    sd_block_xfer xfer_i (
        .clk_sys(clk_sys), .card_is_reset(card_is_reset), .sd_cs(sd_cs),
        .rx_valid(rx_valid), .rx_byte(rx_byte), .byte_start(byte_start),
        .resp_byte(resp_byte), .start_read(start_read), .start_write(start_write),
        .lba(lba), .sd_ack(sd_ack), .buf_rdata(buf_rdata), .tx_byte(tx_byte),
        .xfer_active(xfer_active), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
        .sd_busy(sd_busy), .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_we(buf_we)
    );

    // port a to the io controller, port b to the card
    sector_ram ram_i (
        .clk_sys(clk_sys),
        .a_addr(sd_buff_addr), .a_wdata(sd_buff_dout), .a_we(buff_we_a),
        .a_rdata(sd_buff_din),
        .b_addr(buf_addr), .b_wdata(buf_wdata), .b_we(buf_we), .b_rdata(buf_rdata)
    );

endmodule

`default_nettype wire

//--- tb_sd_card.sv
/* sd card spi testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_sd_card;
    import sd_spi_pkg::*;

    localparam int SCK_HALF      = 4;
    localparam int NUM_CMDS      = 24;
    localparam int NUM_XFERS     = 7;
    localparam int MAX_ACK_DELAY = 40;
    // byte slots before giving up on a token or on busy
    localparam int POLL_LIMIT    = 64;
    // every byte is 8 bits of two sck phases
    localparam int EST_BYTES  = NUM_CMDS * 16 + NUM_XFERS * (SECTOR_BYTES + 40);
    localparam int EST_CYCLES = EST_BYTES * 8 * 2 * SCK_HALF + NUM_XFERS * MAX_ACK_DELAY;
    // power-up done and the 2.7 to 3.6 V window, capacity bit clear
    localparam logic [31:0] EXP_OCR = (32'd1 << 31) | (32'h1FF << 15);

    logic       clk_sys;
    logic       card_is_reset;
    logic       sd_cs;
    logic       sd_sck;
    logic       sd_sdi;
    logic       sd_ack;
    sect_addr_t sd_buff_addr;
    sd_byte_t   sd_buff_dout;
    logic       sd_buff_wr;
    logic       sd_sdo;
    sd_lba_t    sd_lba;
    logic       sd_rd;
    logic       sd_wr;
    logic       sd_busy;
    sd_byte_t   sd_buff_din;

    int       n_checks;
    int       n_errors;
    int       err_mark;
    int       test_no;
    // reference model of the command table
    logic     m_idle_seen;
    logic     m_app;
    sd_byte_t exp_q [$];
    // io controller model, last request and sector contents
    sd_lba_t  io_lba;
    logic     io_was_rd;
    int       io_count;
    sd_byte_t sect_model [SECTOR_BYTES];
    sd_byte_t io_rb [SECTOR_BYTES];
    sd_byte_t wr_data [SECTOR_BYTES];

    sd_card_spi dut_i (
        .clk_sys(clk_sys), .card_is_reset(card_is_reset), .sd_cs(sd_cs),
        .sd_sck(sd_sck), .sd_sdi(sd_sdi), .sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
        .sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr), .sd_sdo(sd_sdo),
        .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_busy(sd_busy),
        .sd_buff_din(sd_buff_din)
    );

    initial begin : clock_gen
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        n_errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic close_test(input string name);
        test_no++;
        $display("test %0d %s: %s", test_no, name, (n_errors == err_mark) ? "passed" : "failed");
        err_mark = n_errors;
    endtask

    // mode 3 byte exchange, host samples sdo just before the rising edge
    task automatic spi_byte(input sd_byte_t tx, output sd_byte_t rx);
        sd_byte_t got;
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk_sys);
            sd_sck <= 1'b0;
            sd_sdi <= tx[i];
            repeat (SCK_HALF) @(posedge clk_sys);
            got[i] = sd_sdo;
            sd_sck <= 1'b1;
            repeat (SCK_HALF - 1) @(posedge clk_sys);
        end
        rx = got;
    endtask

    // expected R1 and extra bytes, app flag lasts one command
    function automatic void model_reply(input sd_byte_t cmd, input logic [31:0] arg);
        logic app;
        app = m_app;
        m_app = 1'b0;
        exp_q.delete();
        if (cmd == CMD_GO_IDLE) begin
            m_idle_seen = 1'b1;
            exp_q.push_back(R1_IDLE);
        end else if (!m_idle_seen) begin
            exp_q.push_back(R1_ILLEGAL);
        end else begin
            case (cmd)
                CMD_SEND_OP_COND, CMD_CRC_ON_OFF, CMD_READ_SINGLE, CMD_WRITE_BLOCK:
                    exp_q.push_back(R1_READY);
                CMD_SEND_IF_COND: begin
                    exp_q.push_back(R1_IDLE);
                    exp_q.push_back(8'h00);
                    exp_q.push_back(8'h00);
                    exp_q.push_back({4'h0, arg[19:16]});
                    exp_q.push_back(arg[7:0]);
                end
                CMD_SEND_STATUS: begin
                    exp_q.push_back(R1_READY);
                    exp_q.push_back(8'h00);
                end
                CMD_SET_BLOCKLEN:
                    exp_q.push_back((arg == 32'd512) ? R1_READY : R1_PARAM_ERR);
                CMD_APP_CMD: begin
                    exp_q.push_back(R1_IDLE);
                    m_app = 1'b1;
                end
                CMD_APP_OP_COND:
                    exp_q.push_back(app ? R1_READY : R1_ILLEGAL);
                CMD_READ_OCR: begin
                    exp_q.push_back(R1_READY);
                    for (int b = 3; b >= 0; b--)
                        exp_q.push_back(EXP_OCR[8*b +: 8]);
                end
                default:
                    exp_q.push_back(R1_ILLEGAL);
            endcase
        end
    endfunction

    // six byte frame, ncr fill, then the model's reply bytes
    task automatic run_cmd(input sd_byte_t cmd, input logic [31:0] arg);
        sd_byte_t rx;
        model_reply(cmd, arg);
        spi_byte(cmd, rx);
        for (int i = 3; i >= 0; i--)
            spi_byte(arg[8*i +: 8], rx);
        // crc byte, valid for CMD0 only
        spi_byte(8'h95, rx);
        for (int i = 0; i < NCR_BYTES; i++) begin
            spi_byte(8'hFF, rx);
            compare_value("sd_sdo ncr fill", rx, 8'hFF);
        end
        foreach (exp_q[i]) begin
            spi_byte(8'hFF, rx);
            compare_value("sd_sdo reply", rx, exp_q[i]);
        end
    endtask

    task automatic write_block(input logic [22:0] sector);
        sd_byte_t rx;
        int       n;
        int       reqs;
        logic     done;
        reqs = io_count;
        run_cmd(CMD_WRITE_BLOCK, {sector, 9'd0});
        spi_byte(8'hFF, rx);
        spi_byte(DATA_TOKEN, rx);
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            wr_data[i] = sd_byte_t'($urandom);
            spi_byte(wr_data[i], rx);
        end
        spi_byte(sd_byte_t'($urandom), rx);
        spi_byte(sd_byte_t'($urandom), rx);
        spi_byte(8'hFF, rx);
        compare_value("sd_sdo data response", rx, DATA_RESP_OK);
        // low bytes while the io controller holds busy
        n = 0;
        done = 1'b0;
        while (!done && n < POLL_LIMIT) begin
            spi_byte(8'hFF, rx);
            n++;
            if (rx == 8'hFF)
                done = 1'b1;
            else
                compare_value("sd_sdo busy", rx, 8'h00);
        end
        if (!done)
            note_failure("write: the card was still busy after the poll limit");
        compare_value("sd_busy", sd_busy, 1'b0);
        compare_value("io request count", io_count - reqs, 1);
        compare_value("sd_rd at request", io_was_rd, 1'b0);
        compare_value("sd_lba", io_lba, {9'd0, sector});
        for (int i = 0; i < SECTOR_BYTES; i++)
            compare_value("sd_buff_din", io_rb[i], wr_data[i]);
    endtask

    task automatic read_block(input logic [22:0] sector, input logic inject);
        sd_byte_t rx;
        sd_byte_t tx;
        int       n;
        int       reqs;
        logic     found;
        reqs = io_count;
        run_cmd(CMD_READ_SINGLE, {sector, 9'd0});
        // optional CMD13 frame while the card waits, it must stay unanswered
        n = 0;
        found = 1'b0;
        while (!found && n < POLL_LIMIT) begin
            tx = 8'hFF;
            if (inject && n == 0)
                tx = CMD_SEND_STATUS;
            else if (inject && n < 5)
                tx = 8'h00;
            spi_byte(tx, rx);
            n++;
            if (rx != 8'hFF)
                found = 1'b1;
        end
        if (!found)
            note_failure("read: no data token arrived within the poll limit");
        else
            compare_value("sd_sdo token", rx, DATA_TOKEN);
        compare_value("io request count", io_count - reqs, 1);
        compare_value("sd_rd at request", io_was_rd, 1'b1);
        compare_value("sd_lba", io_lba, {9'd0, sector});
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            spi_byte(8'hFF, rx);
            compare_value("sd_sdo read data", rx, sect_model[i]);
        end
        for (int i = 0; i < 2; i++) begin
            spi_byte(8'hFF, rx);
            compare_value("sd_sdo crc filler", rx, 8'hFF);
        end
    endtask

    // io controller, random ack delay, fills or drains port a under ack
    initial begin : io_ctrl_model
        int delay;
        io_count = 0;
        sd_ack       <= 1'b0;
        sd_buff_addr <= '0;
        sd_buff_dout <= '0;
        sd_buff_wr   <= 1'b0;
        forever begin
            @(posedge clk_sys);
            if (sd_rd || sd_wr) begin
                io_count++;
                io_lba    = sd_lba;
                io_was_rd = sd_rd;
                delay = $urandom_range(MAX_ACK_DELAY, 0);
                repeat (delay) @(posedge clk_sys);
                sd_ack <= 1'b1;
                @(posedge clk_sys);
                if (io_was_rd) begin
                    for (int i = 0; i < SECTOR_BYTES; i++) begin
                        sect_model[i] = sd_byte_t'($urandom);
                        sd_buff_addr <= sect_addr_t'(i);
                        sd_buff_dout <= sect_model[i];
                        sd_buff_wr   <= 1'b1;
                        @(posedge clk_sys);
                    end
                    sd_buff_wr <= 1'b0;
                end else begin
                    // read data trails the address by one cycle
                    for (int i = 0; i <= SECTOR_BYTES; i++) begin
                        if (i < SECTOR_BYTES)
                            sd_buff_addr <= sect_addr_t'(i);
                        @(posedge clk_sys);
                        if (i > 0)
                            io_rb[i - 1] = sd_buff_din;
                    end
                end
                sd_ack <= 1'b0;
                while (sd_busy)
                    @(posedge clk_sys);
            end
        end
    end

    initial begin : watchdog
        repeat (4 * EST_CYCLES) @(posedge clk_sys);
        $display("timeout: the tests did not finish within %0d cycles", 4 * EST_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main_seq
        sd_byte_t    rx;
        logic [31:0] len;
        void'($urandom(6));
        n_checks    = 0;
        n_errors    = 0;
        err_mark    = 0;
        test_no     = 0;
        m_idle_seen = 1'b0;
        m_app       = 1'b0;
        card_is_reset <= 1'b1;
        sd_cs  <= 1'b1;
        sd_sck <= 1'b1;
        sd_sdi <= 1'b1;
        repeat (3) @(posedge clk_sys);
        card_is_reset <= 1'b0;
        @(posedge clk_sys);

        compare_value("sd_rd", sd_rd, 1'b0);
        compare_value("sd_wr", sd_wr, 1'b0);
        compare_value("sd_busy", sd_busy, 1'b0);
        // deselected card keeps sdo high
        spi_byte(8'h55, rx);
        compare_value("sd_sdo deselected", rx, 8'hFF);
        sd_cs <= 1'b0;
        repeat (4) @(posedge clk_sys);
        run_cmd(CMD_SEND_OP_COND, 32'd0);
        close_test("reset and command before CMD0");

        run_cmd(CMD_GO_IDLE, 32'd0);
        run_cmd(CMD_SEND_IF_COND, {20'd0, 4'h1, sd_byte_t'($urandom)});
        run_cmd(CMD_APP_CMD, 32'd0);
        run_cmd(CMD_APP_OP_COND, 32'h4000_0000);
        run_cmd(CMD_APP_OP_COND, 32'd0);
        run_cmd(CMD_READ_OCR, 32'd0);
        run_cmd(CMD_SEND_STATUS, 32'd0);
        run_cmd(CMD_CRC_ON_OFF, 32'd0);
        run_cmd(CMD_SEND_OP_COND, 32'd0);
        close_test("initialization");

        run_cmd(CMD_SET_BLOCKLEN, 32'd512);
        len = $urandom_range(4096, 1);
        if (len == 32'd512)
            len = 32'd1024;
        run_cmd(CMD_SET_BLOCKLEN, len);
        close_test("block length");

        write_block(23'($urandom));
        close_test("single block write");

        read_block(23'($urandom), 1'b0);
        close_test("single block read");

        for (int k = 0; k < 5; k++) begin
            if ($urandom_range(1, 0) == 1)
                write_block(23'($urandom));
            else
                read_block(23'($urandom), $urandom_range(1, 0) == 1);
        end
        close_test("random transfers");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
sd_spi_pkg.sv
spi_byte_link.sv
sd_cmd_engine.sv
sd_block_xfer.sv
sector_ram.sv
sd_card_spi.sv
tb_sd_card.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the sd card testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_sd_card
./obj_dir/Vtb_sd_card > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "pass message found in sim.log"
else
    echo "pass message missing from sim.log"
    exit 1
fi
